/* core_branch.sv */
`timescale 1ns/1ns
`default_nettype none

module core_branch (
    input  logic                     reset,
    input  cpu_pkg::id_regs_t        id_regs,
    input  cpu_pkg::ex_regs_t        ex_regs,
    input  logic [cpu_pkg::xlen-1:0] pc4,
    input  logic [cpu_pkg::xlen-1:0] epc,
    input  logic                     taken_handler,
    output logic [cpu_pkg::xlen-1:0] next_pc,
    output logic                     flush,
    output logic                     squash_id,
    output logic                     ex_redirect,
    output logic                     eret_taken
);
    import cpu_pkg::*;

    assign ex_redirect = ex_regs.valid &&
                         ((ex_regs.op == OP_BC) || (ex_regs.op == OP_BAL) ||
                          ((ex_regs.op == OP_BEQ) && ex_regs.zero) ||
                          ((ex_regs.op == OP_BNE) && !ex_regs.zero));

    always_comb begin
        next_pc    = pc4;
        flush      = 1'b0;
        squash_id  = 1'b0;
        eret_taken = 1'b0;
        if (reset) begin
            next_pc   = reset_pc;
            flush     = 1'b1;
            squash_id = 1'b1;
        end else if (ex_redirect) begin
            next_pc   = ex_regs.pc_branch;  // Both younger slots are wrong path
            flush     = 1'b1;
            squash_id = 1'b1;
        end else if (taken_handler) begin
            next_pc   = handler_addr;
            flush     = 1'b1;
            squash_id = 1'b1;
        end else if (id_regs.valid && id_regs.eret) begin
            next_pc    = epc;
            flush      = 1'b1;
            eret_taken = 1'b1;
        end else if (id_regs.valid) begin
            case (id_regs.control_type)
                J: begin
                    next_pc = id_regs.jump_addr;
                    flush   = 1'b1;
                end
                JR: begin
                    next_pc = id_regs.a_data;  // rb value for JR and JALR
                    flush   = 1'b1;
                end
                default: begin
                    next_pc = pc4;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input  logic             clk,
    input  logic             reset,
    input  logic             commit_ready,
    input  logic             commit_valid,
    input  cpu_pkg::commit_t commit
);
    // EX is emptied by reset, so nothing is offered on the next cycle
    commit_idle_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
        else $error("commit_valid high in the cycle after reset");

    // A refused record must be offered again unchanged
    commit_stable_on_stall: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
        else $error("commit record changed while stalled");

    // Register zero is hard wired, so no write may carry data to it
    no_r0_write: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && commit.wr_en) |-> !((commit.wr_idx == '0) && (commit.wr_data != '0)))
        else $error("commit writes nonzero data to r0");

endmodule

bind core_top core_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .commit_ready (commit_ready),
    .commit_valid (commit_valid),
    .commit       (commit)
);

`default_nettype wire

/* core_cp0.sv */
`timescale 1ns/1ns
`default_nettype none

module core_cp0 (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     advance,
    input  logic                     irq,
    input  logic                     id_valid,
    input  logic [cpu_pkg::xlen-1:0] id_pc,
    input  logic                     ex_redirect,
    input  logic                     eret_taken,
    output logic                     taken_handler,
    output logic [cpu_pkg::xlen-1:0] epc
);
    logic in_handler;

    // An EX branch wins, so the saved PC is always on the correct path
    assign taken_handler = irq && !in_handler && id_valid && !ex_redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_handler <= 1'b0;
        end else if (advance) begin
            if (taken_handler) begin
                in_handler <= 1'b1;
            end else if (eret_taken) begin
                in_handler <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && taken_handler) begin
            epc <= id_pc;  // The ID instruction is squashed and replays after ERET
        end
    end

endmodule

`default_nettype wire

/* core_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module core_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  logic                       squash,
    input  logic                       if_valid,
    input  logic [cpu_pkg::xlen-1:0]   if_pc,
    input  logic [cpu_pkg::ilen-1:0]   if_instr,
    input  cpu_pkg::commit_t           ex_commit,
    input  logic                       ex_commit_valid,
    input  logic                       wr_en,
    input  logic [cpu_pkg::reg_aw-1:0] wr_idx,
    input  logic [cpu_pkg::xlen-1:0]   wr_data,
    output cpu_pkg::id_regs_t          id_regs,
    output cpu_pkg::id_regs_t          id_ex
);
    import cpu_pkg::*;

    op_t               op;
    logic [reg_aw-1:0] ra;
    logic [reg_aw-1:0] rb;
    logic [reg_aw-1:0] rd_idx_a;
    logic [15:0]       imm;
    logic [xlen-1:0]   rf_a;
    logic [xlen-1:0]   rf_b;
    logic              hit_a;
    logic              hit_b;

    assign op  = op_t'(if_instr[31:28]);
    assign ra  = if_instr[27:25];
    assign rb  = if_instr[24:22];
    assign imm = if_instr[15:0];

    // JR and JALR take their target from rb, so port A reads rb for them
    assign rd_idx_a = (op == OP_JR || op == OP_JALR) ? rb : ra;

    core_regfile u_regfile (
        .clk       (clk),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rb),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b)
    );

    // The EX result lands in the file on the same edge that this ID moves on
    assign hit_a = ex_commit_valid && ex_commit.wr_en && (ex_commit.wr_idx == rd_idx_a);
    assign hit_b = ex_commit_valid && ex_commit.wr_en && (ex_commit.wr_idx == rb);

    always_comb begin
        id_regs.valid     = if_valid;
        id_regs.pc        = if_pc;
        id_regs.op        = op;
        id_regs.ra_idx    = ra;
        id_regs.a_data    = hit_a ? ex_commit.wr_data : rf_a;
        id_regs.b_data    = hit_b ? ex_commit.wr_data : rf_b;
        id_regs.imm       = (op == OP_J) ? {{(xlen-16){1'b0}}, imm} : {{(xlen-16){imm[15]}}, imm};
        id_regs.jump_addr = {{(xlen-18){1'b0}}, imm, 2'b00};  // Word index to byte address
        id_regs.eret      = (op == OP_ERET);
        case (op)
            OP_J:             id_regs.control_type = J;
            OP_JR, OP_JALR:   id_regs.control_type = JR;
            default:          id_regs.control_type = NORMAL;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (advance) begin
            id_ex       <= id_regs;
            id_ex.valid <= id_regs.valid && !squash;
        end
        if (reset) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* core_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module core_execute (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance,
    input  logic              squash_ex,
    input  cpu_pkg::id_regs_t id_ex,
    output cpu_pkg::ex_regs_t ex_regs,
    output logic              commit_valid,
    output cpu_pkg::commit_t  commit
);
    import cpu_pkg::*;

    logic            ex_killed;
    logic            ex_valid;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] link;
    logic [xlen-1:0] pc_branch;

    // Set by a full flush, the instruction left in EX must not retire
    always_ff @(posedge clk) begin
        if (reset || squash_ex) begin
            ex_killed <= 1'b1;
        end else if (advance) begin
            ex_killed <= 1'b0;  // A fresh instruction has been loaded
        end
    end

    assign ex_valid  = id_ex.valid && !ex_killed;
    assign sum       = id_ex.b_data + id_ex.imm;
    assign link      = id_ex.pc + xlen'(4);
    assign pc_branch = link + {id_ex.imm[xlen-3:0], 2'b00};

    always_comb begin
        ex_regs.valid     = ex_valid;
        ex_regs.op        = id_ex.op;
        ex_regs.zero      = (id_ex.a_data == id_ex.b_data);
        ex_regs.pc_branch = pc_branch;
    end

    // Retired record, held steady by the ID/EX register while stalled
    always_comb begin
        commit.pc      = id_ex.pc;
        commit.wr_en   = 1'b0;
        commit.wr_idx  = id_ex.ra_idx;
        commit.wr_data = sum;
        case (id_ex.op)
            OP_ADDI: begin
                commit.wr_en = (id_ex.ra_idx != '0);  // r0 writes are dropped
            end
            OP_BAL: begin
                commit.wr_en   = 1'b1;
                commit.wr_idx  = link_reg;
                commit.wr_data = link;
            end
            OP_JALR: begin
                commit.wr_en   = (id_ex.ra_idx != '0);
                commit.wr_data = link;
            end
            default: begin
                commit.wr_en = 1'b0;
            end
        endcase
    end

    assign commit_valid = ex_valid;

endmodule

`default_nettype wire

/* core_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module core_fetch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        advance,
    input  logic                        flush,
    input  logic [cpu_pkg::xlen-1:0]    next_pc,
    input  logic                        prog_valid,
    input  logic [cpu_pkg::imem_aw-1:0] prog_addr,
    input  logic [cpu_pkg::ilen-1:0]    prog_data,
    output logic                        if_valid,
    output logic [cpu_pkg::xlen-1:0]    if_pc,
    output logic [cpu_pkg::ilen-1:0]    if_instr,
    output logic [cpu_pkg::xlen-1:0]    pc4
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;
    logic [ilen-1:0] imem [imem_words];

    assign pc4 = pc + xlen'(4);

    always_ff @(posedge clk) begin
        if (prog_valid) begin
            imem[prog_addr] <= prog_data;  // Load port works in any cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (reset) begin
            if_valid <= 1'b0;
        end else if (advance) begin
            if_valid <= !flush;  // Wrong-path word is dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if_pc    <= pc;
            if_instr <= imem[pc[imem_aw+1:2]];  // Word index, byte bits ignored
        end
    end

endmodule

`default_nettype wire

/* core_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module core_regfile (
    input  logic                       clk,
    input  logic                       wr_en,
    input  logic [cpu_pkg::reg_aw-1:0] wr_idx,
    input  logic [cpu_pkg::xlen-1:0]   wr_data,
    input  logic [cpu_pkg::reg_aw-1:0] rd_idx_a,
    input  logic [cpu_pkg::reg_aw-1:0] rd_idx_b,
    output logic [cpu_pkg::xlen-1:0]   rd_data_a,
    output logic [cpu_pkg::xlen-1:0]   rd_data_b
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;  // Entry 0 is never written
        end
    end

    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        prog_valid,
    input  logic [cpu_pkg::imem_aw-1:0] prog_addr,
    input  logic [cpu_pkg::ilen-1:0]    prog_data,
    input  logic                        irq,
    input  logic                        commit_ready,
    output logic                        commit_valid,
    output cpu_pkg::commit_t            commit
);
    import cpu_pkg::*;

    logic              advance;
    logic [xlen-1:0]   next_pc;
    logic [xlen-1:0]   pc4;
    logic [xlen-1:0]   epc;
    logic              flush;
    logic              squash_id;
    logic              squash_ex;
    logic              ex_redirect;
    logic              eret_taken;
    logic              taken_handler;
    logic              if_valid;
    logic [xlen-1:0]   if_pc;
    logic [ilen-1:0]   if_instr;
    logic              rf_wr_en;
    id_regs_t          id_regs;
    id_regs_t          id_ex;
    ex_regs_t          ex_regs;

    // A refused commit freezes every stage
    assign advance   = !(commit_valid && !commit_ready);
    assign rf_wr_en  = commit_valid && commit_ready && commit.wr_en;
    assign squash_ex = reset;  // Full flush reaches EX only on reset

    core_fetch u_fetch (
        .clk(clk), .reset(reset), .advance(advance), .flush(flush), .next_pc(next_pc),
        .prog_valid(prog_valid), .prog_addr(prog_addr), .prog_data(prog_data),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr), .pc4(pc4)
    );

    core_decode u_decode (
        .clk(clk), .reset(reset), .advance(advance), .squash(squash_id),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .ex_commit(commit), .ex_commit_valid(commit_valid),
        .wr_en(rf_wr_en), .wr_idx(commit.wr_idx), .wr_data(commit.wr_data),
        .id_regs(id_regs), .id_ex(id_ex)
    );

    core_execute u_execute (
        .clk(clk), .reset(reset), .advance(advance), .squash_ex(squash_ex),
        .id_ex(id_ex), .ex_regs(ex_regs), .commit_valid(commit_valid), .commit(commit)
    );

    core_cp0 u_cp0 (
        .clk(clk), .reset(reset), .advance(advance), .irq(irq),
        .id_valid(id_regs.valid), .id_pc(id_regs.pc), .ex_redirect(ex_redirect),
        .eret_taken(eret_taken), .taken_handler(taken_handler), .epc(epc)
    );

    core_branch u_branch (
        .reset(reset), .id_regs(id_regs), .ex_regs(ex_regs), .pc4(pc4), .epc(epc),
        .taken_handler(taken_handler), .next_pc(next_pc), .flush(flush),
        .squash_id(squash_id), .ex_redirect(ex_redirect), .eret_taken(eret_taken)
    );

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int ilen       = 32;
    localparam int reg_count  = 8;
    localparam int reg_aw     = $clog2(reg_count);
    localparam int imem_words = 64;
    localparam int imem_aw    = $clog2(imem_words);

    localparam logic [xlen-1:0]   reset_pc     = 32'h0000_0000;
    localparam logic [xlen-1:0]   handler_addr = 32'h0000_00c0;  // Interrupt entry, word 48
    localparam logic [reg_aw-1:0] link_reg     = 3'd7;           // BAL writes its link here

    // Opcode field, bits 31..28 of every instruction
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDI = 4'd1,
        OP_BEQ  = 4'd2,
        OP_BNE  = 4'd3,
        OP_BC   = 4'd4,
        OP_BAL  = 4'd5,
        OP_J    = 4'd6,
        OP_JR   = 4'd7,
        OP_JALR = 4'd8,
        OP_ERET = 4'd9
    } op_t;

    // Redirect kind that is resolved while the instruction sits in ID
    typedef enum logic [1:0] {
        NORMAL,
        J,
        JR
    } control_type_t;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        op_t                 op;
        control_type_t       control_type;
        logic [reg_aw-1:0]   ra_idx;        // Destination or first compare register
        logic [xlen-1:0]     a_data;        // Holds rb for JR and JALR, see decode
        logic [xlen-1:0]     b_data;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     jump_addr;
        logic                eret;
    } id_regs_t;

    typedef struct packed {
        logic                valid;
        op_t                 op;
        logic                zero;
        logic [xlen-1:0]     pc_branch;
    } ex_regs_t;

    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic                wr_en;
        logic [reg_aw-1:0]   wr_idx;
        logic [xlen-1:0]     wr_data;
    } commit_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_core -f verilog.f -o sim_core > build.log 2>&1 \
    && ./obj_dir/sim_core > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core;
    import cpu_pkg::*;

    localparam int cycle_limit = 2000;  // Six runs of 70 load cycles and up to 250 run cycles
    localparam int test_limit  = 250;

    logic                clk;
    logic                reset;
    logic                prog_valid;
    logic [imem_aw-1:0]  prog_addr;
    logic [ilen-1:0]     prog_data;
    logic                irq;
    logic                commit_ready;
    logic                commit_valid;
    commit_t             commit;

    logic [ilen-1:0]     prog [imem_words];
    commit_t             exp_q [$];
    int                  seed;
    int                  cyc;
    int                  got;
    int                  hcount;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    logic                mon_on;
    logic                irq_mode;
    logic                in_hblk;

    core_top UUT (
        .clk(clk), .reset(reset), .prog_valid(prog_valid), .prog_addr(prog_addr),
        .prog_data(prog_data), .irq(irq), .commit_ready(commit_ready),
        .commit_valid(commit_valid), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cyc = 0;
        forever begin
            @(posedge clk);
            cyc++;
            if (cyc >= cycle_limit) begin
                $display("run stopped at the cycle limit of %0d", cycle_limit);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    function automatic logic [31:0] enc(input op_t op, input logic [2:0] ra,
                                        input logic [2:0] rb, input logic [15:0] imm);
        return {op, ra, rb, 6'd0, imm};
    endfunction

    // Unused words hold NOPs tagged with their own address
    task automatic fill_nops();
        for (int i = 0; i < imem_words; i++) begin
            prog[i] = {26'd0, 6'(i)};
        end
    endtask

    // Steps the program under the ISA rules to build the expected commit list
    task automatic build_expected(input int n);
        logic [31:0] r [reg_count];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] simm;
        logic [31:0] nxt;
        commit_t     c;
        op_t         op;
        exp_q.delete();
        for (int i = 0; i < reg_count; i++) r[i] = '0;
        pc = reset_pc;
        for (int k = 0; k < n; k++) begin
            ins  = prog[pc[7:2]];
            op   = op_t'(ins[31:28]);
            simm = {{16{ins[15]}}, ins[15:0]};
            nxt  = pc + 32'd4;
            c.pc = pc;
            c.wr_en = 1'b0;
            c.wr_idx = ins[27:25];
            c.wr_data = '0;
            case (op)
                OP_ADDI: begin
                    c.wr_data = r[ins[24:22]] + simm;
                    c.wr_en = (ins[27:25] != 3'd0);
                end
                OP_BEQ: if (r[ins[27:25]] == r[ins[24:22]]) nxt = pc + 32'd4 + (simm << 2);
                OP_BNE: if (r[ins[27:25]] != r[ins[24:22]]) nxt = pc + 32'd4 + (simm << 2);
                OP_BC:  nxt = pc + 32'd4 + (simm << 2);
                OP_BAL: begin
                    nxt = pc + 32'd4 + (simm << 2);
                    c.wr_en = 1'b1;
                    c.wr_idx = link_reg;
                    c.wr_data = pc + 32'd4;
                end
                OP_J:  nxt = {14'd0, ins[15:0], 2'b00};
                OP_JR: nxt = r[ins[24:22]];
                OP_JALR: begin
                    nxt = r[ins[24:22]];
                    c.wr_data = pc + 32'd4;
                    c.wr_en = (ins[27:25] != 3'd0);
                end
                default: ;
            endcase
            if (c.wr_en) r[c.wr_idx] = c.wr_data;
            exp_q.push_back(c);
            pc = nxt;
        end
    endtask

    // Handler commits are counted and left out of the in-order match
    always @(posedge clk) begin
        if (mon_on && commit_valid && commit_ready) begin
            if (irq_mode && commit.pc >= handler_addr) begin
                if (!in_hblk) begin
                    assert (commit.pc == handler_addr) else begin
                        $display("mismatch commit.pc at handler entry exp %h got %h",
                                 handler_addr, commit.pc);
                        errors++;
                    end
                    hcount++;
                end
                in_hblk = 1'b1;
            end else if (got < exp_q.size()) begin
                in_hblk = 1'b0;
                assert (commit.pc == exp_q[got].pc) else begin
                    $display("mismatch commit.pc exp %h got %h", exp_q[got].pc, commit.pc);
                    errors++;
                end
                assert (commit.wr_en == exp_q[got].wr_en) else begin
                    $display("mismatch commit.wr_en exp %h got %h",
                             exp_q[got].wr_en, commit.wr_en);
                    errors++;
                end
                if (exp_q[got].wr_en && commit.wr_en) begin
                    assert (commit.wr_idx == exp_q[got].wr_idx) else begin
                        $display("mismatch commit.wr_idx exp %h got %h",
                                 exp_q[got].wr_idx, commit.wr_idx);
                        errors++;
                    end
                    assert (commit.wr_data == exp_q[got].wr_data) else begin
                        $display("mismatch commit.wr_data exp %h got %h",
                                 exp_q[got].wr_data, commit.wr_data);
                        errors++;
                    end
                end
                got++;
            end
        end
    end

    task automatic run_program(input string name, input int n, input logic with_irq,
                               input logic stall);
        int err_before;
        int waited;
        int r;
        err_before = errors;
        build_expected(n);
        @(posedge clk);
        #1;
        reset = 1'b1;
        mon_on = 1'b0;
        irq = 1'b0;
        commit_ready = 1'b1;
        for (int i = 0; i < imem_words; i++) begin
            prog_valid = 1'b1;
            prog_addr = 6'(i);
            prog_data = prog[i];
            @(posedge clk);
            #1;
        end
        prog_valid = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        got = 0;
        hcount = 0;
        in_hblk = 1'b0;
        irq_mode = with_irq;
        reset = 1'b0;
        mon_on = 1'b1;
        waited = 0;
        while (got < n && waited < test_limit) begin
            @(posedge clk);
            #1;
            waited++;
            if (stall) begin
                r = $random(seed);
                commit_ready = r[0];
            end
            if (with_irq) irq = (got >= 4) && (hcount == 0);  // Dropped once the handler runs
        end
        mon_on = 1'b0;
        irq = 1'b0;
        commit_ready = 1'b1;
        assert (got == n) else begin
            $display("test %s timed out after %0d of %0d commits", name, got, n);
            errors++;
        end
        if (with_irq) begin
            assert (hcount == 1) else begin
                $display("test %s saw %0d handler entries instead of one", name, hcount);
                errors++;
            end
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic addi_program();
        fill_nops();
        prog[0] = enc(OP_ADDI, 3'd1, 3'd0, 16'd5);
        prog[1] = enc(OP_ADDI, 3'd2, 3'd1, 16'd3);     // Reads r1 through the bypass
        prog[2] = enc(OP_ADDI, 3'd3, 3'd2, 16'hffff);
        prog[3] = enc(OP_ADDI, 3'd0, 3'd3, 16'd7);     // Discarded
        prog[4] = enc(OP_ADDI, 3'd4, 3'd0, 16'd1);
        prog[5] = enc(OP_ADDI, 3'd5, 3'd4, 16'h0010);
        prog[6] = enc(OP_ADDI, 3'd1, 3'd5, 16'h7fff);
        prog[7] = enc(OP_J, 3'd0, 3'd0, 16'd7);         // Parks on itself
    endtask

    task automatic branch_program();
        fill_nops();
        prog[0]  = enc(OP_ADDI, 3'd1, 3'd0, 16'd3);
        prog[1]  = enc(OP_ADDI, 3'd2, 3'd0, 16'd3);
        prog[2]  = enc(OP_BEQ, 3'd1, 3'd2, 16'd1);      // Taken
        prog[3]  = enc(OP_ADDI, 3'd3, 3'd0, 16'd99);
        prog[4]  = enc(OP_BNE, 3'd1, 3'd2, 16'd1);      // Not taken
        prog[5]  = enc(OP_ADDI, 3'd3, 3'd0, 16'd1);
        prog[6]  = enc(OP_BNE, 3'd1, 3'd3, 16'd1);      // Taken
        prog[7]  = enc(OP_ADDI, 3'd4, 3'd0, 16'd99);
        prog[8]  = enc(OP_BEQ, 3'd1, 3'd3, 16'd5);      // Not taken
        prog[9]  = enc(OP_BC, 3'd0, 3'd0, 16'd1);
        prog[10] = enc(OP_ADDI, 3'd5, 3'd0, 16'd99);
        prog[11] = enc(OP_BAL, 3'd0, 3'd0, 16'd1);
        prog[12] = enc(OP_ADDI, 3'd5, 3'd0, 16'd98);
        prog[13] = enc(OP_ADDI, 3'd6, 3'd7, 16'd1);
        prog[14] = enc(OP_J, 3'd0, 3'd0, 16'd14);
    endtask

    task automatic jump_program();
        fill_nops();
        prog[0] = enc(OP_ADDI, 3'd1, 3'd0, 16'h0014);
        prog[1] = enc(OP_J, 3'd0, 3'd0, 16'd3);
        prog[2] = enc(OP_ADDI, 3'd2, 3'd0, 16'd99);
        prog[3] = enc(OP_JR, 3'd0, 3'd1, 16'd0);
        prog[4] = enc(OP_ADDI, 3'd2, 3'd0, 16'd98);
        prog[5] = enc(OP_ADDI, 3'd3, 3'd0, 16'h0020);
        prog[6] = enc(OP_JALR, 3'd4, 3'd3, 16'd0);
        prog[7] = enc(OP_ADDI, 3'd2, 3'd0, 16'd97);
        prog[8] = enc(OP_ADDI, 3'd5, 3'd4, 16'd1);
        prog[9] = enc(OP_J, 3'd0, 3'd0, 16'd9);
    endtask

    task automatic irq_loop_program();
        fill_nops();
        prog[0]  = enc(OP_ADDI, 3'd1, 3'd0, 16'd0);
        prog[1]  = enc(OP_ADDI, 3'd2, 3'd0, 16'd5);
        prog[2]  = enc(OP_ADDI, 3'd1, 3'd1, 16'd1);
        prog[3]  = enc(OP_BNE, 3'd1, 3'd2, 16'hfffe);  // Back to word 2
        prog[4]  = enc(OP_ADDI, 3'd3, 3'd1, 16'd100);
        prog[5]  = enc(OP_J, 3'd0, 3'd0, 16'd5);
        prog[48] = enc(OP_ADDI, 3'd6, 3'd6, 16'd1);
        prog[49] = enc(OP_ERET, 3'd0, 3'd0, 16'd0);
    endtask

    initial begin
        seed = 32'hb7c;
        reset = 1'b1;
        prog_valid = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        irq = 1'b0;
        commit_ready = 1'b1;
        mon_on = 1'b0;
        irq_mode = 1'b0;
        in_hblk = 1'b0;
        got = 0;
        hcount = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        addi_program();
        run_program("addi_chain", 10, 1'b0, 1'b0);
        branch_program();
        run_program("branches", 13, 1'b0, 1'b0);
        jump_program();
        run_program("jumps", 9, 1'b0, 1'b0);
        irq_loop_program();
        run_program("irq_in_loop", 17, 1'b1, 1'b0);
        addi_program();
        run_program("addi_chain_stalled", 10, 1'b0, 1'b1);
        branch_program();
        run_program("branches_stalled", 13, 1'b0, 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
cpu_pkg.sv
core_regfile.sv
core_fetch.sv
core_decode.sv
core_execute.sv
core_cp0.sv
core_branch.sv
core_top.sv
core_checker.sv
tb_core.sv
